/* flist.f */
cache_geom_pkg.sv
cache_ctrl_pkg.sv
cache_tag_store.sv
cache_data_store.sv
plru_replacer.sv
line_transfer.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP ?= tb_dcache
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG = TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_dcache.sv */
module tb_dcache;
	timeunit 1ns;
	timeprecision 1ns;
	import cache_ctrl_pkg::*;

	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_ACCESSES = 48;
	// worst case of a write-back plus refill under memory stalls
	localparam int MISS_CYCLES = 150;
	localparam int RSP_HOLD = 6;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_ACCESSES * (MISS_CYCLES + RSP_HOLD);

	logic clk = 1'b0;
	logic rst;
	logic cpu_req_valid;
	cpu_op_t cpu_req_op;
	logic [31:0] cpu_req_addr;
	logic [31:0] cpu_req_wdata;
	logic [3:0] cpu_req_wstrb;
	logic cpu_req_ready;
	logic cpu_rsp_valid;
	logic [31:0] cpu_rsp_data;
	logic cpu_rsp_ready;
	logic mem_rd_req_valid;
	logic [31:0] mem_rd_req_addr;
	logic mem_rd_req_ready;
	logic mem_rd_rsp_valid;
	logic [31:0] mem_rd_rsp_data;
	logic mem_rd_rsp_last;
	logic mem_rd_rsp_ready;
	logic mem_wr_req_valid;
	logic [31:0] mem_wr_req_addr;
	logic mem_wr_req_ready;
	logic mem_wr_data_valid;
	logic [31:0] mem_wr_data;
	logic mem_wr_data_last;
	logic mem_wr_data_ready;

	// latest CPU-visible value of every word that was written
	logic [31:0] ref_mem [bit [31:0]];
	// expected cache contents and tree bits per set
	logic [23:0] m_tag [8][4];
	logic m_valid [8][4];
	logic m_dirty [8][4];
	logic [2:0] m_plru [8];
	int errors;
	int checks;

	dcache_top dcache_top_i (.*);

	tb_mem_model mem_i (.*);

	always #(CLK_HALF) clk = ~clk;

	function automatic logic [31:0] initial_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[11:0], addr[31:12]};
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		if (ref_mem.exists(addr)) return ref_mem[addr];
		return initial_word(addr);
	endfunction

	// take the lowest invalid way before walking the tree
	function automatic int pick_victim(input int set_no);
		for (int w = 0; w < 4; w++) begin
			if (!m_valid[set_no][w]) return w;
		end
		if (m_plru[set_no][0]) return m_plru[set_no][2] ? 3 : 2;
		return m_plru[set_no][1] ? 1 : 0;
	endfunction

	task automatic touch_way(input int set_no, input int way);
		m_plru[set_no][0] = (way < 2);
		if (way < 2) begin
			m_plru[set_no][1] = (way == 0);
		end else begin
			m_plru[set_no][2] = (way == 2);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail t=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	// one CPU request checked against the cache model and the memory logs
	task automatic cache_access(input cpu_op_t op, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strb, input int hold, output int lat);
		logic [31:0] word_addr;
		logic [31:0] line_addr;
		logic [31:0] victim_addr;
		logic [31:0] exp_data;
		int set_no;
		int way;
		int req_base;
		int beat_base;
		bit hit;
		bit wb;

		word_addr = {addr[31:2], 2'b00};
		line_addr = {addr[31:5], 5'b0};
		set_no = int'(addr[7:5]);
		hit = 1'b0;
		way = 0;
		for (int w = 0; w < 4; w++) begin
			if (m_valid[set_no][w] && m_tag[set_no][w] == addr[31:8]) begin
				hit = 1'b1;
				way = w;
			end
		end
		wb = 1'b0;
		victim_addr = '0;
		if (!hit) begin
			way = pick_victim(set_no);
			wb = m_valid[set_no][way] && m_dirty[set_no][way];
			victim_addr = {m_tag[set_no][way], 3'(set_no), 5'b0};
		end
		req_base = mem_i.req_addr_log.size();
		beat_base = mem_i.beat_data_log.size();

		cpu_req_valid <= 1'b1;
		cpu_req_op <= op;
		cpu_req_addr <= addr;
		cpu_req_wdata <= data;
		cpu_req_wstrb <= strb;
		cpu_rsp_ready <= (hold == 0);
		@(posedge clk);
		while (!cpu_req_ready) @(posedge clk);
		cpu_req_valid <= 1'b0;
		lat = 0;

		if (op == OP_READ) begin
			do begin
				@(posedge clk);
				lat++;
			end while (!cpu_rsp_valid);
			exp_data = expected_word(word_addr);
			check_value("cpu_rsp_data", cpu_rsp_data, exp_data);
			if (hold > 0) begin
				// response must sit still while the CPU stalls
				repeat (hold) begin
					@(posedge clk);
					check_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'd1);
					check_value("cpu_rsp_data", cpu_rsp_data, exp_data);
				end
				cpu_rsp_ready <= 1'b1;
				@(posedge clk);
				check_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'd1);
			end
		end else begin
			do begin
				@(posedge clk);
				lat++;
			end while (!cpu_req_ready);
			exp_data = expected_word(word_addr);
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) exp_data[8*b +: 8] = data[8*b +: 8];
			end
			ref_mem[word_addr] = exp_data;
		end

		// no memory traffic on a hit and the write-back goes first on a dirty victim
		check_value("mem request count", 32'(mem_i.req_addr_log.size() - req_base),
			hit ? 32'd0 : (wb ? 32'd2 : 32'd1));
		if (!hit && mem_i.req_addr_log.size() == req_base + (wb ? 2 : 1)) begin
			if (wb) begin
				check_value("mem_wr_req_addr", mem_i.req_addr_log[req_base], victim_addr);
				check_value("write-back before refill", 32'(mem_i.req_wr_log[req_base]), 32'd1);
				check_value("write beats before refill",
					32'(mem_i.req_beat_log[req_base + 1] - beat_base), 32'd8);
				req_base++;
			end
			check_value("mem_rd_req_addr", mem_i.req_addr_log[req_base], line_addr);
			check_value("refill request kind", 32'(mem_i.req_wr_log[req_base]), 32'd0);
		end
		check_value("write beat count", 32'(mem_i.beat_data_log.size() - beat_base),
			wb ? 32'd8 : 32'd0);
		if (wb && mem_i.beat_data_log.size() == beat_base + 8) begin
			for (int i = 0; i < 8; i++) begin
				check_value("mem_wr_data", mem_i.beat_data_log[beat_base + i],
					expected_word(victim_addr + 32'(4 * i)));
				check_value("mem_wr_data_last", 32'(mem_i.beat_last_log[beat_base + i]),
					32'(i == 7));
			end
		end

		if (!hit) begin
			m_tag[set_no][way] = addr[31:8];
			m_valid[set_no][way] = 1'b1;
			m_dirty[set_no][way] = 1'b0;
		end
		if (op == OP_WRITE) m_dirty[set_no][way] = 1'b1;
		touch_way(set_no, way);
	endtask

	task automatic inspect_reset_outputs();
		check_value("cpu_req_ready", 32'(cpu_req_ready), 32'd1);
		check_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'd0);
		check_value("mem_rd_req_valid", 32'(mem_rd_req_valid), 32'd0);
		check_value("mem_wr_req_valid", 32'(mem_wr_req_valid), 32'd0);
		check_value("mem_wr_data_valid", 32'(mem_wr_data_valid), 32'd0);
		check_value("mem_rd_rsp_ready", 32'(mem_rd_rsp_ready), 32'd0);
	endtask

	task automatic read_miss_then_hit();
		int lat;

		// miss then hit on the same word in set 2
		cache_access(OP_READ, 32'h0000_1048, '0, '0, 0, lat);
		cache_access(OP_READ, 32'h0000_1048, '0, '0, 0, lat);
		check_value("total mem requests", 32'(mem_i.req_addr_log.size()), 32'd1);
	endtask

	task automatic merge_partial_writes();
		int lat;

		cache_access(OP_WRITE, 32'h0000_1048, 32'hdead_beef, 4'b0101, 0, lat);
		cache_access(OP_READ, 32'h0000_1048, '0, '0, 0, lat);
		// line in set 4 is not cached yet
		cache_access(OP_WRITE, 32'h0000_2284, 32'h1234_5678, 4'b0010, 0, lat);
		cache_access(OP_READ, 32'h0000_2284, '0, '0, 0, lat);
	endtask

	task automatic cycle_five_tags();
		int order [11] = '{0, 1, 2, 3, 1, 0, 4, 2, 0, 3, 4};
		int lat;

		// five tags competing for set 5
		foreach (order[i]) begin
			cache_access(OP_READ, {24'h000300 + 24'(order[i]), 8'ha4}, '0, '0, 0, lat);
		end
	endtask

	task automatic evict_dirty_lines();
		logic [3:0] strbs [4] = '{4'b1111, 4'b0011, 4'b1000, 4'b0110};
		int lat;

		// fill set 6 with dirty lines and then force them out
		for (int n = 0; n < 4; n++) begin
			cache_access(OP_WRITE, {24'h000400 + 24'(n), 8'hcc}, 32'ha5a5_0000 + 32'(n),
				strbs[n], 0, lat);
		end
		cache_access(OP_WRITE, 32'h0004_04cc, 32'h7777_8888, 4'b1100, 0, lat);
		cache_access(OP_READ, 32'h0004_04cc, '0, '0, 0, lat);
		// these come back from memory with the merged bytes
		cache_access(OP_READ, 32'h0004_00cc, '0, '0, 0, lat);
		cache_access(OP_READ, 32'h0004_01cc, '0, '0, 0, lat);
	endtask

	task automatic stall_response_and_memory();
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		cpu_op_t op;
		int lat;

		cache_access(OP_READ, 32'h0000_1048, '0, '0, RSP_HOLD, lat);
		cache_access(OP_READ, 32'h0000_5ee0, '0, '0, 4, lat);
		// random mix over six tags in sets 0 and 1
		repeat (8) begin
			addr = 32'h0006_0000 | (($urandom % 6) << 8) | (($urandom % 2) << 5)
				| (($urandom % 8) << 2);
			data = $urandom;
			strb = 4'($urandom % 16);
			op = ($urandom % 2) != 0 ? OP_WRITE : OP_READ;
			cache_access(op, addr, data, strb, 0, lat);
		end
	endtask

	task automatic measure_hit_latency();
		int lat;

		cache_access(OP_READ, 32'h0000_1048, '0, '0, 0, lat);
		cache_access(OP_READ, 32'h0000_1048, '0, '0, 0, lat);
		check_value("read hit latency", 32'(lat), 32'd3);
		cache_access(OP_WRITE, 32'h0000_1048, 32'h0bad_f00d, 4'b1111, 0, lat);
		check_value("write hit latency", 32'(lat), 32'd3);
	endtask

	initial begin
		void'($urandom(32'hb406f8ba));
		errors = 0;
		checks = 0;
		rst = 1'b1;
		cpu_req_valid = 1'b0;
		cpu_req_op = OP_READ;
		cpu_req_addr = '0;
		cpu_req_wdata = '0;
		cpu_req_wstrb = '0;
		cpu_rsp_ready = 1'b1;
		for (int s = 0; s < 8; s++) begin
			m_plru[s] = '0;
			for (int w = 0; w < 4; w++) begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
			end
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		inspect_reset_outputs();
		read_miss_then_hit();
		merge_partial_writes();
		cycle_five_tags();
		evict_dirty_lines();
		stall_response_and_memory();
		measure_hit_latency();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// bound on the whole run with every access taken as a worst-case miss
	initial begin
		#(WATCHDOG_CYCLES * 2 * CLK_HALF);
		$display("watchdog expired after %0d cycles with tests still running",
			WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* tb_mem_model.sv */
module tb_mem_model (
	input logic clk,
	input logic rst,
	input logic mem_rd_req_valid,
	input logic [31:0] mem_rd_req_addr,
	output logic mem_rd_req_ready,
	output logic mem_rd_rsp_valid,
	output logic [31:0] mem_rd_rsp_data,
	output logic mem_rd_rsp_last,
	input logic mem_rd_rsp_ready,
	input logic mem_wr_req_valid,
	input logic [31:0] mem_wr_req_addr,
	output logic mem_wr_req_ready,
	input logic mem_wr_data_valid,
	input logic [31:0] mem_wr_data,
	input logic mem_wr_data_last,
	output logic mem_wr_data_ready
);
	timeunit 1ns;
	timeprecision 1ns;

	// words written by bursts override the fill pattern
	logic [31:0] store [bit [31:0]];
	// accepted requests in order
	logic [31:0] req_addr_log [$];
	// set for a write-back request
	logic req_wr_log [$];
	// write beats already taken when each request was accepted
	int req_beat_log [$];
	// every write beat with its last flag
	logic [31:0] beat_data_log [$];
	logic beat_last_log [$];

	logic rd_busy;
	logic [31:0] rd_addr;
	int rd_beat;
	logic wr_busy;
	logic [31:0] wr_addr;
	int wr_beat;

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[11:0], addr[31:12]};
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] addr);
		if (store.exists(addr)) return store[addr];
		return fill_word(addr);
	endfunction

	// ready about three cycles in four
	function automatic logic random_ready();
		return ($urandom % 4) != 0;
	endfunction

	initial begin
		mem_rd_req_ready = 1'b0;
		mem_rd_rsp_valid = 1'b0;
		mem_rd_rsp_data = '0;
		mem_rd_rsp_last = 1'b0;
		mem_wr_req_ready = 1'b0;
		mem_wr_data_ready = 1'b0;
		rd_busy = 1'b0;
		rd_addr = '0;
		rd_beat = 0;
		wr_busy = 1'b0;
		wr_addr = '0;
		wr_beat = 0;
		forever begin
			@(posedge clk);
			if (rst) begin
				rd_busy = 1'b0;
				wr_busy = 1'b0;
				mem_rd_req_ready <= 1'b0;
				mem_rd_rsp_valid <= 1'b0;
				mem_wr_req_ready <= 1'b0;
				mem_wr_data_ready <= 1'b0;
			end else begin
				// beats that moved on this edge
				if (mem_rd_rsp_valid && mem_rd_rsp_ready) begin
					rd_beat++;
					if (rd_beat == 8) rd_busy = 1'b0;
				end
				if (mem_wr_data_valid && mem_wr_data_ready) begin
					store[wr_addr + 32'(4 * wr_beat)] = mem_wr_data;
					beat_data_log.push_back(mem_wr_data);
					beat_last_log.push_back(mem_wr_data_last);
					wr_beat++;
					if (wr_beat == 8) wr_busy = 1'b0;
				end
				// new bursts
				if (mem_wr_req_valid && mem_wr_req_ready) begin
					wr_busy = 1'b1;
					wr_addr = mem_wr_req_addr;
					wr_beat = 0;
					req_addr_log.push_back(mem_wr_req_addr);
					req_wr_log.push_back(1'b1);
					req_beat_log.push_back(beat_data_log.size());
				end
				if (mem_rd_req_valid && mem_rd_req_ready) begin
					rd_busy = 1'b1;
					rd_addr = mem_rd_req_addr;
					rd_beat = 0;
					req_addr_log.push_back(mem_rd_req_addr);
					req_wr_log.push_back(1'b0);
					req_beat_log.push_back(beat_data_log.size());
				end
				mem_rd_req_ready <= !rd_busy && random_ready();
				mem_wr_req_ready <= !wr_busy && random_ready();
				mem_wr_data_ready <= wr_busy && random_ready();
				// a beat on offer stays until the cache takes it
				if (!(mem_rd_rsp_valid && !mem_rd_rsp_ready)) begin
					mem_rd_rsp_valid <= rd_busy && random_ready();
					mem_rd_rsp_data <= read_word(rd_addr + 32'(4 * rd_beat));
					mem_rd_rsp_last <= (rd_beat == 7);
				end
			end
		end
	end

endmodule

/* dcache_top.sv */
module dcache_top (
	input logic clk,
	input logic rst,
	input logic cpu_req_valid,
	input cache_ctrl_pkg::cpu_op_t cpu_req_op,
	input logic [31:0] cpu_req_addr,
	input logic [31:0] cpu_req_wdata,
	input logic [3:0] cpu_req_wstrb,
	output logic cpu_req_ready,
	output logic cpu_rsp_valid,
	output logic [31:0] cpu_rsp_data,
	input logic cpu_rsp_ready,
	output logic mem_rd_req_valid,
	output logic [31:0] mem_rd_req_addr,
	input logic mem_rd_req_ready,
	input logic mem_rd_rsp_valid,
	input logic [31:0] mem_rd_rsp_data,
	input logic mem_rd_rsp_last,
	output logic mem_rd_rsp_ready,
	output logic mem_wr_req_valid,
	output logic [31:0] mem_wr_req_addr,
	input logic mem_wr_req_ready,
	output logic mem_wr_data_valid,
	output logic [31:0] mem_wr_data,
	output logic mem_wr_data_last,
	input logic mem_wr_data_ready
);
	import cache_geom_pkg::*;

	// lookup and select
	set_idx_t set_idx;
	tag_t req_tag;
	word_idx_t word_idx;
	way_mask_t sel_way;
	way_mask_t hit_way;
	way_mask_t valid_ways;
	way_mask_t victim_way;
	tag_t sel_tag;
	logic hit;
	logic sel_dirty;
	// store updates
	logic write_word;
	logic refill_en;
	logic touch_en;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	// line movement
	line_t sel_line;
	line_t refill_line;
	logic wb_start;
	logic wb_done;
	logic rf_start;
	logic rf_done;

	dcache_ctrl ctrl_i (.*);

	cache_tag_store tag_store_i (.*);

	// read data goes to the CPU straight from the selected word
	cache_data_store data_store_i (
		.clk(clk),
		.set_idx(set_idx),
		.sel_way(sel_way),
		.word_idx(word_idx),
		.refill_en(refill_en),
		.refill_line(refill_line),
		.write_word(write_word),
		.wdata(wdata),
		.wstrb(wstrb),
		.sel_line(sel_line),
		.rd_word(cpu_rsp_data)
	);

	plru_replacer plru_i (.*);

	// write-back takes the victim line from the data store
	line_transfer xfer_i (
		.wb_line(sel_line),
		.*
	);

endmodule

/* dcache_ctrl.sv */
module dcache_ctrl (
	input logic clk,
	input logic rst,
	input logic cpu_req_valid,
	input cache_ctrl_pkg::cpu_op_t cpu_req_op,
	input logic [31:0] cpu_req_addr,
	input logic [31:0] cpu_req_wdata,
	input logic [3:0] cpu_req_wstrb,
	output logic cpu_req_ready,
	output logic cpu_rsp_valid,
	input logic cpu_rsp_ready,
	output logic mem_rd_req_valid,
	output logic [31:0] mem_rd_req_addr,
	input logic mem_rd_req_ready,
	output logic mem_wr_req_valid,
	output logic [31:0] mem_wr_req_addr,
	input logic mem_wr_req_ready,
	input logic hit,
	input cache_geom_pkg::way_mask_t hit_way,
	input cache_geom_pkg::way_mask_t victim_way,
	input cache_geom_pkg::tag_t sel_tag,
	input logic sel_dirty,
	input logic wb_done,
	input logic rf_done,
	output cache_geom_pkg::set_idx_t set_idx,
	output cache_geom_pkg::tag_t req_tag,
	output cache_geom_pkg::word_idx_t word_idx,
	output cache_geom_pkg::way_mask_t sel_way,
	output logic write_word,
	output logic [31:0] wdata,
	output logic [3:0] wstrb,
	output logic refill_en,
	output logic touch_en,
	output logic wb_start,
	output logic rf_start
);
	import cache_geom_pkg::*;
	import cache_ctrl_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	cpu_op_t req_op;
	logic [31:0] req_addr;

	// hold the accepted request for the whole transaction
	always_ff @(posedge clk) begin
		if (cpu_req_valid && cpu_req_ready) begin
			req_op <= cpu_req_op;
			req_addr <= cpu_req_addr;
			wdata <= cpu_req_wdata;
			wstrb <= cpu_req_wstrb;
		end
	end

	assign req_tag = req_addr[31 -: TAG_W];
	assign set_idx = req_addr[5 +: SET_W];
	assign word_idx = req_addr[2 +: WORD_IDX_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			sel_way <= '0;
		end else begin
			state <= next_state;
			// hit way on a hit, otherwise the victim, so EVICT sees its dirty bit
			if (state == TAG_CHECK && hit) begin
				sel_way <= hit_way;
			end else if (state == TAG_CHECK || state == EVICT) begin
				sel_way <= victim_way;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: if (cpu_req_valid) next_state = TAG_CHECK;
			TAG_CHECK: begin
				if (!hit) begin
					next_state = EVICT;
				end else begin
					next_state = (req_op == OP_WRITE) ? WRITE_HIT : READ_HIT;
				end
			end
			// clean victims skip straight to the refill
			EVICT: next_state = sel_dirty ? WB_REQ : RF_REQ;
			WB_REQ: if (mem_wr_req_ready) next_state = WB_DATA;
			WB_DATA: if (wb_done) next_state = RF_REQ;
			RF_REQ: if (mem_rd_req_ready) next_state = RF_DATA;
			RF_DATA: if (rf_done) next_state = REFILL;
			REFILL: next_state = (req_op == OP_WRITE) ? WRITE_HIT : READ_HIT;
			WRITE_HIT: next_state = IDLE;
			READ_HIT: next_state = RESPOND;
			RESPOND: if (cpu_rsp_ready) next_state = IDLE;
			default: next_state = IDLE;
		endcase
	end

	assign cpu_req_ready = (state == IDLE);
	assign cpu_rsp_valid = (state == RESPOND);
	assign mem_wr_req_valid = (state == WB_REQ);
	assign mem_rd_req_valid = (state == RF_REQ);
	// both burst addresses are line aligned
	assign mem_wr_req_addr = {sel_tag, set_idx, 5'b0};
	assign mem_rd_req_addr = {req_tag, set_idx, 5'b0};
	assign wb_start = mem_wr_req_valid && mem_wr_req_ready;
	assign rf_start = mem_rd_req_valid && mem_rd_req_ready;
	assign refill_en = (state == REFILL);
	assign write_word = (state == WRITE_HIT);
	assign touch_en = (state == READ_HIT) || (state == WRITE_HIT);

endmodule

/* line_transfer.sv */
module line_transfer (
	input logic clk,
	input logic rst,
	input logic wb_start,
	input cache_geom_pkg::line_t wb_line,
	input logic mem_wr_data_ready,
	output logic mem_wr_data_valid,
	output logic [cache_geom_pkg::WORD_W-1:0] mem_wr_data,
	output logic mem_wr_data_last,
	output logic wb_done,
	input logic rf_start,
	input logic mem_rd_rsp_valid,
	input logic [cache_geom_pkg::WORD_W-1:0] mem_rd_rsp_data,
	input logic mem_rd_rsp_last,
	output logic mem_rd_rsp_ready,
	output cache_geom_pkg::line_t refill_line,
	output logic rf_done
);
	import cache_geom_pkg::*;

	logic wb_active;
	word_idx_t wb_cnt;
	line_t wb_shift;
	logic wb_beat;
	logic rf_active;
	logic rf_beat;

	assign wb_beat = wb_active && mem_wr_data_ready;
	assign rf_beat = rf_active && mem_rd_rsp_valid;

	// write-back side sends the low word and shifts down per accepted beat
	assign mem_wr_data_valid = wb_active;
	assign mem_wr_data = wb_shift[WORD_W-1:0];
	assign mem_wr_data_last = wb_active && (wb_cnt == word_idx_t'(WORDS_PER_LINE - 1));
	assign mem_rd_rsp_ready = rf_active;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_active <= 1'b0;
			wb_cnt <= '0;
			wb_done <= 1'b0;
			rf_active <= 1'b0;
			rf_done <= 1'b0;
		end else begin
			// done flags trail the last beat by one cycle
			wb_done <= wb_beat && mem_wr_data_last;
			rf_done <= rf_beat && mem_rd_rsp_last;
			if (wb_start) begin
				wb_active <= 1'b1;
				wb_cnt <= '0;
			end else if (wb_beat) begin
				wb_cnt <= wb_cnt + 1'b1;
				wb_active <= !mem_wr_data_last;
			end
			if (rf_start) begin
				rf_active <= 1'b1;
			end else if (rf_beat && mem_rd_rsp_last) begin
				rf_active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wb_start) begin
			wb_shift <= wb_line;
		end else if (wb_beat) begin
			wb_shift <= {{WORD_W{1'b0}}, wb_shift[LINE_W-1:WORD_W]};
		end
		// beats enter at the top so the first one ends up in word 0
		if (rf_beat) begin
			refill_line <= {mem_rd_rsp_data, refill_line[LINE_W-1:WORD_W]};
		end
	end

endmodule

/* plru_replacer.sv */
module plru_replacer (
	input logic clk,
	input logic rst,
	input cache_geom_pkg::set_idx_t set_idx,
	input cache_geom_pkg::way_mask_t valid_ways,
	input logic touch_en,
	input cache_geom_pkg::way_mask_t sel_way,
	output cache_geom_pkg::way_mask_t victim_way
);
	import cache_geom_pkg::*;

	// bit 0 picks the pair, bit 1 within ways 0/1, bit 2 within ways 2/3
	logic [2:0] plru_q [NUM_SETS];
	logic [2:0] cur_bits;
	logic touch_low_pair;

	assign cur_bits = plru_q[set_idx];
	assign touch_low_pair = sel_way[0] | sel_way[1];

	always_comb begin
		victim_way = '0;
		if (&valid_ways) begin
			// tree walk once every way holds a line
			if (cur_bits[0]) begin
				victim_way = cur_bits[2] ? 4'b1000 : 4'b0100;
			end else begin
				victim_way = cur_bits[1] ? 4'b0010 : 4'b0001;
			end
		end else begin
			// scan down so the lowest invalid way wins
			for (int w = NUM_WAYS - 1; w >= 0; w--) begin
				if (!valid_ways[w]) begin
					victim_way = '0;
					victim_way[w] = 1'b1;
				end
			end
		end
	end

	// point the tree away from the way just used
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				plru_q[s] <= '0;
			end
		end else if (touch_en) begin
			plru_q[set_idx][0] <= touch_low_pair;
			if (touch_low_pair) begin
				plru_q[set_idx][1] <= sel_way[0];
			end else begin
				plru_q[set_idx][2] <= sel_way[2];
			end
		end
	end

endmodule

/* cache_data_store.sv */
module cache_data_store (
	input logic clk,
	input cache_geom_pkg::set_idx_t set_idx,
	input cache_geom_pkg::way_mask_t sel_way,
	input cache_geom_pkg::word_idx_t word_idx,
	input logic refill_en,
	input cache_geom_pkg::line_t refill_line,
	input logic write_word,
	input logic [cache_geom_pkg::WORD_W-1:0] wdata,
	input logic [cache_geom_pkg::WORD_W/8-1:0] wstrb,
	output cache_geom_pkg::line_t sel_line,
	output logic [cache_geom_pkg::WORD_W-1:0] rd_word
);
	import cache_geom_pkg::*;

	line_t data_mem [NUM_WAYS][NUM_SETS];
	logic [WORD_W-1:0] merged_word;

	// one-hot way select over the current set
	always_comb begin
		sel_line = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			sel_line = sel_line | ({LINE_W{sel_way[w]}} & data_mem[w][set_idx]);
		end
	end

	assign rd_word = sel_line[word_idx*WORD_W +: WORD_W];

	// strobed bytes from the CPU, the rest kept from the cached word
	always_comb begin
		for (int b = 0; b < WORD_W/8; b++) begin
			merged_word[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : rd_word[8*b +: 8];
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (sel_way[w] && refill_en) begin
				data_mem[w][set_idx] <= refill_line;
			end else if (sel_way[w] && write_word) begin
				data_mem[w][set_idx][word_idx*WORD_W +: WORD_W] <= merged_word;
			end
		end
	end

endmodule

/* cache_tag_store.sv */
module cache_tag_store (
	input logic clk,
	input logic rst,
	input cache_geom_pkg::set_idx_t set_idx,
	input cache_geom_pkg::tag_t req_tag,
	input cache_geom_pkg::way_mask_t sel_way,
	input logic refill_en,
	input logic write_word,
	output logic hit,
	output cache_geom_pkg::way_mask_t hit_way,
	output cache_geom_pkg::way_mask_t valid_ways,
	output cache_geom_pkg::tag_t sel_tag,
	output logic sel_dirty
);
	import cache_geom_pkg::*;

	tag_t tag_mem [NUM_WAYS][NUM_SETS];
	// one bit per set in each way
	logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
	logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];

	// new tag goes in on refill of the chosen way
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (refill_en && sel_way[w]) begin
				tag_mem[w][set_idx] <= req_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (sel_way[w] && refill_en) begin
					// fresh line from memory is clean
					valid_q[w][set_idx] <= 1'b1;
					dirty_q[w][set_idx] <= 1'b0;
				end else if (sel_way[w] && write_word) begin
					dirty_q[w][set_idx] <= 1'b1;
				end
			end
		end
	end

	// compare all ways in parallel, mux out the selected way's tag and dirty bit
	always_comb begin
		sel_tag = '0;
		sel_dirty = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			valid_ways[w] = valid_q[w][set_idx];
			hit_way[w] = valid_q[w][set_idx] && (tag_mem[w][set_idx] == req_tag);
			sel_tag = sel_tag | ({TAG_W{sel_way[w]}} & tag_mem[w][set_idx]);
			sel_dirty = sel_dirty | (sel_way[w] & dirty_q[w][set_idx]);
		end
	end

	assign hit = |hit_way;

endmodule

/* cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} cpu_op_t;

	// controller states, write-back before refill on a dirty miss
	typedef enum logic [3:0] {
		IDLE, TAG_CHECK, EVICT, WB_REQ, WB_DATA, RF_REQ,
		RF_DATA, REFILL, WRITE_HIT, READ_HIT, RESPOND
	} ctrl_state_t;

endpackage

/* cache_geom_pkg.sv */
package cache_geom_pkg;

	// four ways of eight sets, 32-byte lines
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 8;
	localparam int SET_W = 3;
	// address split is tag 31..8, set 7..5, word 4..2
	localparam int TAG_W = 24;
	localparam int WORD_W = 32;
	localparam int WORDS_PER_LINE = 8;
	localparam int WORD_IDX_W = 3;
	localparam int LINE_W = WORD_W * WORDS_PER_LINE;

	typedef logic [SET_W-1:0] set_idx_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [WORD_IDX_W-1:0] word_idx_t;
	// word 0 sits in the low 32 bits
	typedef logic [LINE_W-1:0] line_t;
	// bit n stands for way n
	typedef logic [NUM_WAYS-1:0] way_mask_t;

endpackage
